//--- include/pkt_filter_macros.svh
`ifndef PKT_FILTER_MACROS_SVH
`define PKT_FILTER_MACROS_SVH

// stream beat and routing tag widths
`define PF_BEAT_W 128
`define PF_TAG_W 12

// key field offsets in the first beat
// proto is 8 bits, addresses 32, port 16
`define PF_PROTO_LSB 88
`define PF_SRC_LSB 56
`define PF_DST_LSB 24
`define PF_PORT_LSB 8

// size of the fixed rule table
`define PF_NUM_RULES 4

// key queue between capture and matcher
`define PF_KEY_FIFO_DEPTH 16
// two slots spare for the capture register in flight
`define PF_KEY_FIFO_AFULL 14

// accepted results waiting for the consumer
`define PF_RES_FIFO_DEPTH 8

`endif

//--- hdl/pkt_filter_pkg.sv
`include "pkt_filter_macros.svh"

package pkt_filter_pkg;

	typedef struct packed {
		logic                  sop;
		logic                  eop;
		logic [`PF_TAG_W-1:0]  tag;
		logic [`PF_BEAT_W-1:0] data;
	} beat_t;

	typedef struct packed {
		logic [7:0]  proto;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] dst_port;
	} header_key_t;

	// key FIFO word
	typedef struct packed {
		logic [`PF_TAG_W-1:0] tag;
		header_key_t          key;
	} tagged_key_t;

	typedef enum logic {
		ACT_DROP,
		ACT_ACCEPT
	} action_e;

	typedef struct packed {
		header_key_t value;
		header_key_t mask;
		action_e     action;
	} rule_t;

	typedef logic [$clog2(`PF_NUM_RULES)-1:0] rule_idx_t;

	typedef struct packed {
		logic [`PF_TAG_W-1:0] tag;
		rule_idx_t            rule;
	} match_result_t;

	typedef enum logic {
		CAP_IDLE,
		CAP_BODY
	} cap_state_e;

	// lowest index wins when several rules hit
	localparam rule_t RULES [`PF_NUM_RULES] = '{
		// ssh from 10.0.0.0/8
		'{value: '{8'd6, 32'h0a00_0000, 32'h0000_0000, 16'd22},
		  mask:  '{8'hff, 32'hff00_0000, 32'h0000_0000, 16'hffff},
		  action: ACT_ACCEPT},
		// anything towards 192.168.1.0/24
		'{value: '{8'd0, 32'h0000_0000, 32'hc0a8_0100, 16'd0},
		  mask:  '{8'h00, 32'h0000_0000, 32'hffff_ff00, 16'h0000},
		  action: ACT_DROP},
		// web over tcp
		'{value: '{8'd6, 32'h0000_0000, 32'h0000_0000, 16'd80},
		  mask:  '{8'hff, 32'h0000_0000, 32'h0000_0000, 16'hffff},
		  action: ACT_ACCEPT},
		// all udp
		'{value: '{8'd17, 32'h0000_0000, 32'h0000_0000, 16'd0},
		  mask:  '{8'hff, 32'h0000_0000, 32'h0000_0000, 16'h0000},
		  action: ACT_ACCEPT}
	};

endpackage

//--- hdl/header_capture.sv
`timescale 1ns/1ps
`include "pkt_filter_macros.svh"

module header_capture
	import pkt_filter_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  beat_t       beat,
	input  logic        beat_valid,
	output tagged_key_t key_data,
	output logic        key_valid,
	input  logic        key_ready
);

	cap_state_e  state;
	header_key_t key_hold;
	header_key_t beat_key;
	header_key_t pkt_key;
	logic        take_sop;
	logic        take_eop;

	// key fields as they sit in the first beat
	assign beat_key.proto    = beat.data[`PF_PROTO_LSB +: 8];
	assign beat_key.src_ip   = beat.data[`PF_SRC_LSB +: 32];
	assign beat_key.dst_ip   = beat.data[`PF_DST_LSB +: 32];
	assign beat_key.dst_port = beat.data[`PF_PORT_LSB +: 16];

	// in_ready is gated at the top, so valid alone means accepted
	assign take_sop = beat_valid && beat.sop;

	// eop only closes a packet that was opened
	assign take_eop = beat_valid && beat.eop && (beat.sop || state == CAP_BODY);

	// single-beat packets bypass the holding register
	assign pkt_key = beat.sop ? beat_key : key_hold;

	// packet framing
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= CAP_IDLE;
		end else if (take_eop) begin
			state <= CAP_IDLE;
		end else if (take_sop) begin
			// a stray sop mid-packet restarts framing
			state <= CAP_BODY;
		end
	end

	// header fields from the sop beat only
	always_ff @(posedge clock) begin
		if (take_sop) begin
			key_hold <= beat_key;
		end
	end

	// key stays offered until the key FIFO takes it
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			key_valid <= 1'b0;
		end else if (take_eop) begin
			key_valid <= 1'b1;
		end else if (key_ready) begin
			key_valid <= 1'b0;
		end
	end

	// tag rides on the eop beat
	always_ff @(posedge clock) begin
		if (take_eop) begin
			key_data.tag <= beat.tag;
			key_data.key <= pkt_key;
		end
	end

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	parameter int AFULL = DEPTH - 2
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             wr_en,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// wrap at DEPTH, not only at powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// overflow and underflow requests are dropped here
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign full        = (count == CNT_W'(DEPTH));
	assign almost_full = (count >= CNT_W'(AFULL));
	assign empty       = (count == '0);

	// show-ahead head
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- hdl/rule_match.sv
`timescale 1ns/1ps
`include "pkt_filter_macros.svh"

module rule_match
	import pkt_filter_pkg::*;
(
	input  logic          clock,
	input  logic          rst_n,
	input  tagged_key_t   key_data,
	input  logic          key_valid,
	output logic          key_ready,
	output match_result_t res_data,
	output logic          res_valid,
	input  logic          res_ready
);

	logic [`PF_NUM_RULES-1:0] hits;
	logic                     s1_valid;
	logic [`PF_TAG_W-1:0]     s1_tag;
	logic [`PF_NUM_RULES-1:0] s1_hits;
	logic                     s1_advance;
	rule_idx_t                win_idx;
	logic                     win_accept;
	logic                     s2_valid;
	logic [`PF_TAG_W-1:0]     s2_tag;
	rule_idx_t                s2_rule;
	logic                     s2_advance;

	// every rule compared in parallel, masked bits must equal the value
	always_comb begin
		for (int i = 0; i < `PF_NUM_RULES; i++) begin
			hits[i] = (((key_data.key ^ RULES[i].value) & RULES[i].mask) == '0);
		end
	end

	// a dropped key leaves stage 2 empty, so it never blocks
	assign s2_advance = !s2_valid || res_ready;
	assign s1_advance = !s1_valid || s2_advance;

	// pops the key FIFO
	assign key_ready = s1_advance;

	// stage 1: tag and hit vector
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else if (s1_advance) begin
			s1_valid <= key_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (s1_advance && key_valid) begin
			s1_tag  <= key_data.tag;
			s1_hits <= hits;
		end
	end

	// first hit wins, scan from the top so the lowest index is last
	always_comb begin
		win_idx = '0;
		for (int i = `PF_NUM_RULES - 1; i >= 0; i--) begin
			if (s1_hits[i]) begin
				win_idx = rule_idx_t'(i);
			end
		end
		win_accept = (|s1_hits) && (RULES[win_idx].action == ACT_ACCEPT);
	end

	// stage 2: only accepted winners become valid
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
		end else if (s2_advance) begin
			s2_valid <= s1_valid && win_accept;
		end
	end

	always_ff @(posedge clock) begin
		if (s2_advance && s1_valid) begin
			s2_tag  <= s1_tag;
			s2_rule <= win_idx;
		end
	end

	assign res_valid     = s2_valid;
	assign res_data.tag  = s2_tag;
	assign res_data.rule = s2_rule;

endmodule

//--- hdl/match_block.sv
`timescale 1ns/1ps
`include "pkt_filter_macros.svh"

module match_block
	import pkt_filter_pkg::*;
(
	input  logic          clock,
	input  logic          rst_n,
	input  beat_t         in_beat,
	input  logic          in_valid,
	output logic          in_ready,
	output match_result_t out_result,
	output logic          out_valid,
	input  logic          out_ready
);

	tagged_key_t   cap_key;
	logic          cap_key_valid;
	tagged_key_t   key_head;
	logic          key_full;
	logic          key_almost_full;
	logic          key_empty;
	logic          match_key_ready;
	match_result_t match_res;
	logic          match_res_valid;
	logic          res_full;
	logic          res_empty;

	// back-pressure reaches the stream through the key FIFO level
	assign in_ready  = !key_almost_full;
	assign out_valid = !res_empty;

	header_capture u_capture (
		.clock      (clock),
		.rst_n      (rst_n),
		.beat       (in_beat),
		.beat_valid (in_valid),
		.key_data   (cap_key),
		.key_valid  (cap_key_valid),
		.key_ready  (!key_full)
	);

	sync_fifo #(
		.WIDTH ($bits(tagged_key_t)),
		.DEPTH (`PF_KEY_FIFO_DEPTH),
		.AFULL (`PF_KEY_FIFO_AFULL)
	) u_key_fifo (
		.clock       (clock),
		.rst_n       (rst_n),
		.wr_data     (cap_key),
		.wr_en       (cap_key_valid),
		.rd_en       (match_key_ready),
		.rd_data     (key_head),
		.full        (key_full),
		.almost_full (key_almost_full),
		.empty       (key_empty)
	);

	rule_match u_match (
		.clock     (clock),
		.rst_n     (rst_n),
		.key_data  (key_head),
		.key_valid (!key_empty),
		.key_ready (match_key_ready),
		.res_data  (match_res),
		.res_valid (match_res_valid),
		.res_ready (!res_full)
	);

	// result queue, level only matters when full
	sync_fifo #(
		.WIDTH ($bits(match_result_t)),
		.DEPTH (`PF_RES_FIFO_DEPTH),
		.AFULL (`PF_RES_FIFO_DEPTH)
	) u_res_fifo (
		.clock       (clock),
		.rst_n       (rst_n),
		.wr_data     (match_res),
		.wr_en       (match_res_valid),
		.rd_en       (out_ready),
		.rd_data     (out_result),
		.full        (res_full),
		.almost_full (),
		.empty       (res_empty)
	);

endmodule

//--- tb/match_block_properties.sv
`timescale 1ns/1ps

module match_block_properties
	import pkt_filter_pkg::*;
(
	input logic          clock,
	input logic          rst_n,
	input match_result_t out_result,
	input logic          out_valid,
	input logic          out_ready
);

	// a stalled result stays offered and unchanged
	a_stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_result))
	else $error("out_result changed or out_valid dropped while stalled");

	a_valid_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown(out_valid))
	else $error("out_valid is unknown after reset");

	// result FIFO is empty while reset is held
	a_reset_idle: assert property (@(posedge clock)
		!rst_n |-> !out_valid)
	else $error("out_valid high during reset");

endmodule

//--- tb/match_block_tb.sv
`timescale 1ns/1ps
`include "pkt_filter_macros.svh"

module match_block_tb
	import pkt_filter_pkg::*;
();

	localparam int NUM_ROWS = 16;
	localparam int MAX_CYCLES = 60 * NUM_ROWS + 200;
	// later beats carry a key that would hit rule 3
	localparam header_key_t DECOY = '{8'd17, 32'h0a00_0000, 32'h0505_0505, 16'd22};

	logic          clock = 1'b0;
	logic          rst_n;
	beat_t         in_beat;
	logic          in_valid;
	logic          in_ready;
	match_result_t out_result;
	logic          out_valid;
	logic          out_ready = 1'b1;

	string                row_name [NUM_ROWS];
	header_key_t          row_key [NUM_ROWS];
	int                   row_beats [NUM_ROWS];
	logic [`PF_TAG_W-1:0] row_tag [NUM_ROWS];
	int                   row_rule [NUM_ROWS];
	int                   row_count;

	match_result_t exp_q [$];
	string         exp_name_q [$];
	logic          bp_phase;
	int            seed;
	int            cycles = 0;

	always #20 clock = ~clock;

	match_block dut (
		.clock      (clock),
		.rst_n      (rst_n),
		.in_beat    (in_beat),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.out_result (out_result),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

	bind match_block match_block_properties u_properties (
		.clock      (clock),
		.rst_n      (rst_n),
		.out_result (out_result),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_result(input string name, input match_result_t exp,
		input match_result_t act);
		if (act !== exp) begin
			fail_run($sformatf("MISMATCH %s expected tag=%03h rule=%0d actual tag=%03h rule=%0d",
				name, exp.tag, exp.rule, act.tag, act.rule));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
		end
	endtask

	// lowest hitting rule if it accepts, otherwise -1
	function automatic int predict_rule(input header_key_t key);
		for (int i = 0; i < `PF_NUM_RULES; i++) begin
			if ((key & RULES[i].mask) == (RULES[i].value & RULES[i].mask)) begin
				return (RULES[i].action == ACT_ACCEPT) ? i : -1;
			end
		end
		return -1;
	endfunction

	// key fields at their offsets over a filler pattern
	function automatic logic [`PF_BEAT_W-1:0] beat_data(input header_key_t key, input int fill);
		logic [`PF_BEAT_W-1:0] d;
		d = {4{fill * 32'h9e37_79b9}};
		d[`PF_PROTO_LSB +: 8] = key.proto;
		d[`PF_SRC_LSB +: 32]  = key.src_ip;
		d[`PF_DST_LSB +: 32]  = key.dst_ip;
		d[`PF_PORT_LSB +: 16] = key.dst_port;
		return d;
	endfunction

	task automatic add_row(input string name, input logic [7:0] proto, input logic [31:0] src,
		input logic [31:0] dst, input logic [15:0] port, input int beats,
		input logic [`PF_TAG_W-1:0] tag, input int rule);
		row_name[row_count]  = name;
		row_key[row_count]   = '{proto, src, dst, port};
		row_beats[row_count] = beats;
		row_tag[row_count]   = tag;
		row_rule[row_count]  = rule;
		row_count++;
	endtask

	task automatic send_packet(input int row);
		for (int b = 0; b < row_beats[row]; b++) begin
			// capture takes any valid beat so valid waits for in_ready
			while (!in_ready) begin
				in_valid = 1'b0;
				@(posedge clock);
				#2;
			end
			in_beat.sop  = (b == 0);
			in_beat.eop  = (b == row_beats[row] - 1);
			in_beat.tag  = in_beat.eop ? row_tag[row] : ~row_tag[row];
			in_beat.data = beat_data((b == 0) ? row_key[row] : DECOY, row * 4 + b);
			in_valid     = 1'b1;
			@(posedge clock);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic run_table();
		int pred;
		for (int r = 0; r < row_count; r++) begin
			pred = predict_rule(row_key[r]);
			// table column against the rule model
			check_flag({row_name[r], "_accept"}, row_rule[r] >= 0, pred >= 0);
			if (pred >= 0) begin
				check_result(row_name[r], match_result_t'{row_tag[r], rule_idx_t'(row_rule[r])},
					match_result_t'{row_tag[r], rule_idx_t'(pred)});
				exp_q.push_back(match_result_t'{row_tag[r], rule_idx_t'(pred)});
				exp_name_q.push_back(row_name[r]);
			end
			send_packet(r);
		end
		while (exp_q.size() != 0) begin
			@(posedge clock);
		end
		#2;
	endtask

	// handshake seen between edges completes at the next rising edge
	always @(negedge clock) begin
		if (rst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				fail_run($sformatf("unexpected output with tag %03h and rule %0d",
					out_result.tag, out_result.rule));
			end else begin
				check_result(exp_name_q.pop_front(), exp_q.pop_front(), out_result);
			end
		end
	end

	always @(posedge clock) begin
		#2;
		out_ready = bp_phase ? (($random(seed) & 3) == 0) : 1'b1;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			fail_run($sformatf("timeout, results still missing after %0d cycles", cycles));
		end
	end

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_beat   = '0;
		bp_phase  = 1'b0;
		seed      = 32'hb139037e;
		row_count = 0;
		add_row("ssh_single", 8'd6, 32'h0a01_0203, 32'h0808_0808, 16'd22, 1, 12'h101, 0);
		add_row("web_single", 8'd6, 32'hc612_0001, 32'h0102_0304, 16'd80, 1, 12'h102, 2);
		add_row("udp_single", 8'd17, 32'h0b00_0001, 32'h0a0a_0a0a, 16'd53, 1, 12'h103, 3);
		add_row("icmp_no_hit", 8'd1, 32'h0a00_0001, 32'h0101_0101, 16'd0, 1, 12'h104, -1);
		add_row("lan_web_drop", 8'd6, 32'h0b00_0001, 32'hc0a8_0105, 16'd80, 1, 12'h105, -1);
		add_row("ssh_to_lan", 8'd6, 32'h0a00_0007, 32'hc0a8_0110, 16'd22, 1, 12'h106, 0);
		add_row("web_3beat", 8'd6, 32'h1400_0001, 32'h0303_0303, 16'd80, 3, 12'h207, 2);
		add_row("lan_udp_drop", 8'd17, 32'h0101_0101, 32'hc0a8_01fe, 16'd53, 2, 12'h208, -1);
		add_row("udp_2beat", 8'd17, 32'h0202_0202, 32'h0606_0606, 16'd5000, 2, 12'h209, 3);
		add_row("lan_ssh_drop", 8'd6, 32'h0b00_0002, 32'hc0a8_0101, 16'd22, 3, 12'h20a, -1);
		add_row("https_no_hit", 8'd6, 32'h0b00_0003, 32'h0707_0707, 16'd443, 2, 12'h20b, -1);
		add_row("ssh_3beat", 8'd6, 32'h0aff_ffff, 32'h0909_0909, 16'd22, 3, 12'h30c, 0);
		add_row("ssh_bad_src", 8'd6, 32'h0b00_0000, 32'h0404_0404, 16'd22, 1, 12'h30d, -1);
		add_row("udp_near_lan", 8'd17, 32'h0303_0303, 32'hc0a8_0200, 16'd67, 1, 12'h30e, 3);
		add_row("web_tag_max", 8'd6, 32'h0c00_0001, 32'h0505_0505, 16'd80, 2, 12'hfff, 2);
		add_row("ssh_tag_zero", 8'd6, 32'h0a10_2030, 32'h0b0b_0b0b, 16'd22, 1, 12'h000, 0);
		repeat (8) @(posedge clock);
		#2;
		rst_n = 1'b1;
		@(posedge clock);
		#2;
		check_flag("reset_out_valid", 1'b0, out_valid);
		check_flag("reset_in_ready", 1'b1, in_ready);
		run_table();
		// second pass with a mostly stalled consumer
		@(posedge clock);
		bp_phase = 1'b1;
		#2;
		run_table();
		repeat (10) @(posedge clock);
		#2;
		check_flag("drain_out_valid", 1'b0, out_valid);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
hdl/pkt_filter_pkg.sv
hdl/header_capture.sv
hdl/sync_fifo.sv
hdl/rule_match.sv
hdl/match_block.sv
tb/match_block_properties.sv
tb/match_block_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= match_block_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

# build, run, then look for the pass line in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$($(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
